/* rf_defines.svh */
// Widths are global to the subsystem and the register count is always 2**RF_ADDR_WIDTH
`ifndef RF_DEFINES_SVH
`define RF_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Register file geometry
////////////////////////////////////////////////////////////////////////////

// Register address width, 32 architectural registers
`define RF_ADDR_WIDTH 5

// Register word width
`define RF_DATA_WIDTH 32

////////////////////////////////////////////////////////////////////////////
// Host configuration port
////////////////////////////////////////////////////////////////////////////

// Host register address width, four registers in the map
`define RF_CFG_ADDR_WIDTH 2

`endif

/* rf_pkg.sv */
// Types shared by the BIST engine and the host registers, and the STATUS bit order follows the struct
`include "rf_defines.svh"

package rf_pkg;

   // BIST engine status
   // Packed MSB first, so busy is bit 2 and fail is bit 0
   typedef struct packed
   {
      logic busy;
      logic done;
      logic fail;
   } rf_status_t;

   // Host register map
   typedef enum logic [`RF_CFG_ADDR_WIDTH-1:0]
   {
      // Bit 0 starts the BIST, write-only, reads as zero
      CTRL      = 2'd0,
      // Read-only status word
      STATUS    = 2'd1,
      // Background pattern for the March run
      PATTERN   = 2'd2,
      // First address that failed compare
      FAIL_ADDR = 2'd3
   } rf_cfg_reg_e;

endpackage

/* rf_test_if.sv */
// Single 1RW test port, csn and wen are active low and q follows a test read by one cycle
`timescale 1ns/1ps
`include "rf_defines.svh"

interface rf_test_if;

   // Test mode enable, port A belongs to the test port while high
   logic                      bist_en;
   // Chip select, active low
   logic                      csn;
   // Write enable, low writes and high reads
   logic                      wen;
   logic [`RF_ADDR_WIDTH-1:0] addr;
   logic [`RF_DATA_WIDTH-1:0] wdata;
   // Read data of the last test read
   logic [`RF_DATA_WIDTH-1:0] q;

   // BIST engine side
   modport engine
   (
      output bist_en, csn, wen, addr, wdata,
      input  q
   );

   // Memory wrapper side
   modport mem
   (
      input  bist_en, csn, wen, addr, wdata,
      output q
   );

endinterface

/* rf_regfile.sv */
// Flop array without bypass, so a write shows on the read ports only in the cycle after its edge
`timescale 1ns/1ps
`include "rf_defines.svh"

module rf_regfile
(
   input  logic                      clk,
   input  logic                      rst_n,

   // Read ports, combinational
   input  logic [`RF_ADDR_WIDTH-1:0] raddr_a_i,
   output logic [`RF_DATA_WIDTH-1:0] rdata_a_o,
   input  logic [`RF_ADDR_WIDTH-1:0] raddr_b_i,
   output logic [`RF_DATA_WIDTH-1:0] rdata_b_o,
   input  logic [`RF_ADDR_WIDTH-1:0] raddr_c_i,
   output logic [`RF_DATA_WIDTH-1:0] rdata_c_o,

   // Write port A
   input  logic [`RF_ADDR_WIDTH-1:0] waddr_a_i,
   input  logic [`RF_DATA_WIDTH-1:0] wdata_a_i,
   input  logic                      we_a_i,

   // Write port B, wins over A on the same address
   input  logic [`RF_ADDR_WIDTH-1:0] waddr_b_i,
   input  logic [`RF_DATA_WIDTH-1:0] wdata_b_i,
   input  logic                      we_b_i
);

   localparam int NUM_WORDS = 2 ** `RF_ADDR_WIDTH;

   logic [`RF_DATA_WIDTH-1:0] mem [NUM_WORDS];

   // x0 is hardwired, no storage behind it
   assign mem[0] = '0;

   ////////////////////////////////////////////////////////////////////////////
   // Storage words 1 .. NUM_WORDS-1
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 1; i < NUM_WORDS; i++)
   begin : g_word
      logic hit_a;
      logic hit_b;

      // Per-word write decode
      assign hit_a = we_a_i && (waddr_a_i == `RF_ADDR_WIDTH'(i));
      assign hit_b = we_b_i && (waddr_b_i == `RF_ADDR_WIDTH'(i));

      always_ff @(posedge clk or negedge rst_n)
      begin
         if (!rst_n)
            mem[i] <= '0;
         // Port B checked first for collision priority
         else if (hit_b)
            mem[i] <= wdata_b_i;
         else if (hit_a)
            mem[i] <= wdata_a_i;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read muxes
   ////////////////////////////////////////////////////////////////////////////

   assign rdata_a_o = mem[raddr_a_i];
   assign rdata_b_o = mem[raddr_b_i];
   assign rdata_c_o = mem[raddr_c_i];

endmodule

/* rf_test_wrap.sv */
// While bist_en is high the functional port A is ignored, port B writes are dropped and port A reads test data
`timescale 1ns/1ps
`include "rf_defines.svh"

module rf_test_wrap
(
   input  logic                      clk,
   input  logic                      rst_n,

   // Functional read ports
   input  logic [`RF_ADDR_WIDTH-1:0] raddr_a_i,
   output logic [`RF_DATA_WIDTH-1:0] rdata_a_o,
   input  logic [`RF_ADDR_WIDTH-1:0] raddr_b_i,
   output logic [`RF_DATA_WIDTH-1:0] rdata_b_o,
   input  logic [`RF_ADDR_WIDTH-1:0] raddr_c_i,
   output logic [`RF_DATA_WIDTH-1:0] rdata_c_o,

   // Functional write ports
   input  logic [`RF_ADDR_WIDTH-1:0] waddr_a_i,
   input  logic [`RF_DATA_WIDTH-1:0] wdata_a_i,
   input  logic                      we_a_i,
   input  logic [`RF_ADDR_WIDTH-1:0] waddr_b_i,
   input  logic [`RF_DATA_WIDTH-1:0] wdata_b_i,
   input  logic                      we_b_i,

   // Test port
   rf_test_if.mem                    tst_if
);

   logic                      tst_rd;
   logic                      tst_wr;
   logic [`RF_ADDR_WIDTH-1:0] tst_raddr_q;

   logic [`RF_ADDR_WIDTH-1:0] raddr_a_mux;
   logic [`RF_ADDR_WIDTH-1:0] waddr_a_mux;
   logic [`RF_DATA_WIDTH-1:0] wdata_a_mux;
   logic                      we_a_mux;
   logic [`RF_ADDR_WIDTH-1:0] waddr_b_mux;
   logic [`RF_DATA_WIDTH-1:0] wdata_b_mux;
   logic                      we_b_mux;

   // Decoded test accesses
   assign tst_rd = !tst_if.csn && tst_if.wen;
   assign tst_wr = !tst_if.csn && !tst_if.wen;

   // Test read address, held until the next test read
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         tst_raddr_q <= '0;
      else if (tst_rd)
         tst_raddr_q <= tst_if.addr;
   end

   // Port A taken over by the test port
   assign raddr_a_mux = tst_if.bist_en ? tst_raddr_q  : raddr_a_i;
   assign waddr_a_mux = tst_if.bist_en ? tst_if.addr  : waddr_a_i;
   assign wdata_a_mux = tst_if.bist_en ? tst_if.wdata : wdata_a_i;
   assign we_a_mux    = tst_if.bist_en ? tst_wr       : we_a_i;

   // Port B forced idle during test
   assign waddr_b_mux = tst_if.bist_en ? '0   : waddr_b_i;
   assign wdata_b_mux = tst_if.bist_en ? '0   : wdata_b_i;
   assign we_b_mux    = tst_if.bist_en ? 1'b0 : we_b_i;

   // Test read data taken from read port A
   assign tst_if.q = rdata_a_o;

   rf_regfile u_regfile
   (
      .clk       ( clk         ),
      .rst_n     ( rst_n       ),
      .raddr_a_i ( raddr_a_mux ),
      .rdata_a_o ( rdata_a_o   ),
      .raddr_b_i ( raddr_b_i   ),
      .rdata_b_o ( rdata_b_o   ),
      .raddr_c_i ( raddr_c_i   ),
      .rdata_c_o ( rdata_c_o   ),
      .waddr_a_i ( waddr_a_mux ),
      .wdata_a_i ( wdata_a_mux ),
      .we_a_i    ( we_a_mux    ),
      .waddr_b_i ( waddr_b_mux ),
      .wdata_b_i ( wdata_b_mux ),
      .we_b_i    ( we_b_mux    )
   );

endmodule

/* rf_mbist_ctrl.sv */
// March test over addresses 1..31 only, a start while busy is ignored and only the first fail is kept
`timescale 1ns/1ps
`include "rf_defines.svh"

module rf_mbist_ctrl
   import rf_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,

   // Control from the host registers
   input  logic                      start_i,
   input  logic [`RF_DATA_WIDTH-1:0] pattern_i,
   output rf_status_t                status_o,
   output logic [`RF_ADDR_WIDTH-1:0] fail_addr_o,

   // Test port
   rf_test_if.engine                 tst_if
);

   localparam logic [`RF_ADDR_WIDTH-1:0] ADDR_LO = `RF_ADDR_WIDTH'(1);
   localparam logic [`RF_ADDR_WIDTH-1:0] ADDR_HI = '1;

   // FILL is element 1, the other elements loop ISSUE, CMP, WRITE per address
   typedef enum logic [2:0]
   {
      S_IDLE,
      S_FILL,
      S_ISSUE,
      S_CMP,
      S_WRITE
   } state_e;

   state_e                    state_q;
   logic [1:0]                elem_q;
   logic [`RF_ADDR_WIDTH-1:0] addr_q;
   logic [`RF_DATA_WIDTH-1:0] pat_q;
   logic                      done_q;
   logic                      fail_q;

   logic                      descend;
   logic                      last_addr;
   logic [`RF_DATA_WIDTH-1:0] expect_data;
   logic [`RF_DATA_WIDTH-1:0] write_data;

   ////////////////////////////////////////////////////////////////////////////
   // Element decode
   ////////////////////////////////////////////////////////////////////////////

   // Third element runs downward
   assign descend   = (elem_q == 2'd2);
   assign last_addr = descend ? (addr_q == ADDR_LO) : (addr_q == ADDR_HI);

   // Third element expects ~P and restores P
   assign expect_data = descend ? ~pat_q : pat_q;
   assign write_data  = ((elem_q == 2'd0) || descend) ? pat_q : ~pat_q;

   ////////////////////////////////////////////////////////////////////////////
   // Test port drive
   ////////////////////////////////////////////////////////////////////////////

   assign tst_if.bist_en = (state_q != S_IDLE);
   // CMP is the only idle slot inside a run
   assign tst_if.csn     = (state_q == S_IDLE) || (state_q == S_CMP);
   // Low only for write slots
   assign tst_if.wen     = !((state_q == S_FILL) || (state_q == S_WRITE));
   assign tst_if.addr    = addr_q;
   assign tst_if.wdata   = write_data;

   assign status_o = '{busy: (state_q != S_IDLE), done: done_q, fail: fail_q};

   ////////////////////////////////////////////////////////////////////////////
   // Sequencer
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q     <= S_IDLE;
         elem_q      <= '0;
         addr_q      <= ADDR_LO;
         done_q      <= 1'b0;
         fail_q      <= 1'b0;
         fail_addr_o <= '0;
      end
      else
      begin
         case (state_q)
            S_IDLE:
            begin
               if (start_i)
               begin
                  state_q     <= S_FILL;
                  elem_q      <= '0;
                  addr_q      <= ADDR_LO;
                  done_q      <= 1'b0;
                  fail_q      <= 1'b0;
                  fail_addr_o <= '0;
               end
            end
            // Address goes out now, q is valid next cycle
            S_ISSUE:
               state_q <= S_CMP;
            S_CMP:
            begin
               // Keep the first mismatch only
               if ((tst_if.q != expect_data) && !fail_q)
               begin
                  fail_q      <= 1'b1;
                  fail_addr_o <= addr_q;
               end
               state_q <= S_WRITE;
            end
            S_FILL, S_WRITE:
            begin
               if (!last_addr)
               begin
                  addr_q  <= descend ? addr_q - 1'b1 : addr_q + 1'b1;
                  state_q <= (state_q == S_FILL) ? S_FILL : S_ISSUE;
               end
               else if (elem_q == 2'd3)
               begin
                  // busy falls with done rising
                  state_q <= S_IDLE;
                  done_q  <= 1'b1;
               end
               else
               begin
                  elem_q  <= elem_q + 1'b1;
                  // Element about to start is the descending one
                  addr_q  <= (elem_q == 2'd1) ? ADDR_HI : ADDR_LO;
                  state_q <= S_ISSUE;
               end
            end
            default:
               state_q <= S_IDLE;
         endcase
      end
   end

   // Pattern sampled once per run
   always_ff @(posedge clk)
   begin
      if ((state_q == S_IDLE) && start_i)
         pat_q <= pattern_i;
   end

endmodule

/* rf_bist_regs.sv */
// Host writes stall while the BIST runs, reads always pass and return data one cycle after acceptance
`timescale 1ns/1ps
`include "rf_defines.svh"

module rf_bist_regs
   import rf_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst_n,

   // Host valid/ready port
   input  logic                          cfg_valid_i,
   input  logic                          cfg_write_i,
   input  logic [`RF_CFG_ADDR_WIDTH-1:0] cfg_addr_i,
   input  logic [`RF_DATA_WIDTH-1:0]     cfg_wdata_i,
   output logic                          cfg_ready_o,
   output logic [`RF_DATA_WIDTH-1:0]     cfg_rdata_o,
   output logic                          cfg_rvalid_o,

   // BIST engine side
   input  rf_status_t                    status_i,
   input  logic [`RF_ADDR_WIDTH-1:0]     fail_addr_i,
   output logic                          start_o,
   output logic [`RF_DATA_WIDTH-1:0]     pattern_o
);

   rf_cfg_reg_e               reg_sel;
   logic                      wr_acc;
   logic                      rd_acc;
   logic [`RF_DATA_WIDTH-1:0] rd_mux;

   assign reg_sel = rf_cfg_reg_e'(cfg_addr_i);

   // Pending start counts as busy so a write cannot slip in before the engine reacts
   assign cfg_ready_o = !(cfg_valid_i && cfg_write_i && (status_i.busy || start_o));

   assign wr_acc = cfg_valid_i && cfg_ready_o && cfg_write_i;
   assign rd_acc = cfg_valid_i && cfg_ready_o && !cfg_write_i;

   // Read data select
   always_comb
   begin
      rd_mux = '0;
      case (reg_sel)
         STATUS:    rd_mux = `RF_DATA_WIDTH'(status_i);
         PATTERN:   rd_mux = pattern_o;
         FAIL_ADDR: rd_mux = `RF_DATA_WIDTH'(fail_addr_i);
         // CTRL is write-only
         default:   rd_mux = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Control registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         start_o      <= 1'b0;
         pattern_o    <= '0;
         cfg_rvalid_o <= 1'b0;
      end
      else
      begin
         // Self-clearing start, high for one cycle
         start_o      <= wr_acc && (reg_sel == CTRL) && cfg_wdata_i[0];
         cfg_rvalid_o <= rd_acc;
         if (wr_acc && (reg_sel == PATTERN))
            pattern_o <= cfg_wdata_i;
      end
   end

   // Read data, qualified by cfg_rvalid_o
   always_ff @(posedge clk)
   begin
      if (rd_acc)
         cfg_rdata_o <= rd_mux;
   end

endmodule

/* rf_subsys_top.sv */
// Register file with March BIST, functional port A and B writes are lost while a BIST run is busy
`timescale 1ns/1ps
`include "rf_defines.svh"

module rf_subsys_top
   import rf_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst_n,

   // Host port
   input  logic                          cfg_valid_i,
   input  logic                          cfg_write_i,
   input  logic [`RF_CFG_ADDR_WIDTH-1:0] cfg_addr_i,
   input  logic [`RF_DATA_WIDTH-1:0]     cfg_wdata_i,
   output logic                          cfg_ready_o,
   output logic [`RF_DATA_WIDTH-1:0]     cfg_rdata_o,
   output logic                          cfg_rvalid_o,

   // Functional read ports
   input  logic [`RF_ADDR_WIDTH-1:0]     raddr_a_i,
   output logic [`RF_DATA_WIDTH-1:0]     rdata_a_o,
   input  logic [`RF_ADDR_WIDTH-1:0]     raddr_b_i,
   output logic [`RF_DATA_WIDTH-1:0]     rdata_b_o,
   input  logic [`RF_ADDR_WIDTH-1:0]     raddr_c_i,
   output logic [`RF_DATA_WIDTH-1:0]     rdata_c_o,

   // Functional write ports
   input  logic [`RF_ADDR_WIDTH-1:0]     waddr_a_i,
   input  logic [`RF_DATA_WIDTH-1:0]     wdata_a_i,
   input  logic                          we_a_i,
   input  logic [`RF_ADDR_WIDTH-1:0]     waddr_b_i,
   input  logic [`RF_DATA_WIDTH-1:0]     wdata_b_i,
   input  logic                          we_b_i
);

   rf_status_t                bist_status;
   logic [`RF_ADDR_WIDTH-1:0] bist_fail_addr;
   logic                      bist_start;
   logic [`RF_DATA_WIDTH-1:0] bist_pattern;

   // Engine to wrapper test port
   rf_test_if tst_if ();

   // Host register block
   rf_bist_regs u_regs
   (
      .clk          ( clk            ),
      .rst_n        ( rst_n          ),
      .cfg_valid_i  ( cfg_valid_i    ),
      .cfg_write_i  ( cfg_write_i    ),
      .cfg_addr_i   ( cfg_addr_i     ),
      .cfg_wdata_i  ( cfg_wdata_i    ),
      .cfg_ready_o  ( cfg_ready_o    ),
      .cfg_rdata_o  ( cfg_rdata_o    ),
      .cfg_rvalid_o ( cfg_rvalid_o   ),
      .status_i     ( bist_status    ),
      .fail_addr_i  ( bist_fail_addr ),
      .start_o      ( bist_start     ),
      .pattern_o    ( bist_pattern   )
   );

   // March sequencer
   rf_mbist_ctrl u_mbist
   (
      .clk         ( clk            ),
      .rst_n       ( rst_n          ),
      .start_i     ( bist_start     ),
      .pattern_i   ( bist_pattern   ),
      .status_o    ( bist_status    ),
      .fail_addr_o ( bist_fail_addr ),
      .tst_if      ( tst_if.engine  )
   );

   // Register file behind the test mux
   rf_test_wrap u_wrap
   (
      .clk       ( clk        ),
      .rst_n     ( rst_n      ),
      .raddr_a_i ( raddr_a_i  ),
      .rdata_a_o ( rdata_a_o  ),
      .raddr_b_i ( raddr_b_i  ),
      .rdata_b_o ( rdata_b_o  ),
      .raddr_c_i ( raddr_c_i  ),
      .rdata_c_o ( rdata_c_o  ),
      .waddr_a_i ( waddr_a_i  ),
      .wdata_a_i ( wdata_a_i  ),
      .we_a_i    ( we_a_i     ),
      .waddr_b_i ( waddr_b_i  ),
      .wdata_b_i ( wdata_b_i  ),
      .we_b_i    ( we_b_i     ),
      .tst_if    ( tst_if.mem )
   );

endmodule

/* tb_rf_subsys.sv */
// Needs RF_DATA_WIDTH of 32 and drives on the falling edge, and the run stops at the first error
`timescale 1ns/1ps
`include "rf_defines.svh"

module tb_rf_subsys
   import rf_pkg::*;
();

   localparam int          NUM_WORDS   = 2 ** `RF_ADDR_WIDTH;
   localparam int          WAIT_LIMIT  = 50;
   localparam int          BIST_LIMIT  = 2000;
   localparam logic [31:0] LFSR_SEED   = 32'h211f;
   // x^32 + x^22 + x^2 + x + 1
   localparam logic [31:0] LFSR_TAPS   = 32'h80200003;

   // Functional stimulus modes
   localparam int MODE_RAND    = 0;
   localparam int MODE_COLLIDE = 1;
   localparam int MODE_ZERO    = 2;
   localparam int MODE_READ    = 3;
   localparam int MODE_BLIND   = 4;

   logic                          clk;
   logic                          rst_n;
   logic                          cfg_valid_i;
   logic                          cfg_write_i;
   logic [`RF_CFG_ADDR_WIDTH-1:0] cfg_addr_i;
   logic [`RF_DATA_WIDTH-1:0]     cfg_wdata_i;
   logic                          cfg_ready_o;
   logic [`RF_DATA_WIDTH-1:0]     cfg_rdata_o;
   logic                          cfg_rvalid_o;
   logic [`RF_ADDR_WIDTH-1:0]     raddr_a_i;
   logic [`RF_ADDR_WIDTH-1:0]     raddr_b_i;
   logic [`RF_ADDR_WIDTH-1:0]     raddr_c_i;
   logic [`RF_DATA_WIDTH-1:0]     rdata_a_o;
   logic [`RF_DATA_WIDTH-1:0]     rdata_b_o;
   logic [`RF_DATA_WIDTH-1:0]     rdata_c_o;
   logic [`RF_ADDR_WIDTH-1:0]     waddr_a_i;
   logic [`RF_DATA_WIDTH-1:0]     wdata_a_i;
   logic                          we_a_i;
   logic [`RF_ADDR_WIDTH-1:0]     waddr_b_i;
   logic [`RF_DATA_WIDTH-1:0]     wdata_b_i;
   logic                          we_b_i;

   logic [31:0]               lfsr_q;
   // Expected register contents
   logic [`RF_DATA_WIDTH-1:0] shadow [NUM_WORDS];
   logic                      rd_accept_q;
   logic [31:0]               pat;
   logic [31:0]               pat_next;
   int                        stalls;

   rf_subsys_top uut
   (
      .clk          ( clk          ),
      .rst_n        ( rst_n        ),
      .cfg_valid_i  ( cfg_valid_i  ),
      .cfg_write_i  ( cfg_write_i  ),
      .cfg_addr_i   ( cfg_addr_i   ),
      .cfg_wdata_i  ( cfg_wdata_i  ),
      .cfg_ready_o  ( cfg_ready_o  ),
      .cfg_rdata_o  ( cfg_rdata_o  ),
      .cfg_rvalid_o ( cfg_rvalid_o ),
      .raddr_a_i    ( raddr_a_i    ),
      .rdata_a_o    ( rdata_a_o    ),
      .raddr_b_i    ( raddr_b_i    ),
      .rdata_b_o    ( rdata_b_o    ),
      .raddr_c_i    ( raddr_c_i    ),
      .rdata_c_o    ( rdata_c_o    ),
      .waddr_a_i    ( waddr_a_i    ),
      .wdata_a_i    ( wdata_a_i    ),
      .we_a_i       ( we_a_i       ),
      .waddr_b_i    ( waddr_b_i    ),
      .wdata_b_i    ( wdata_b_i    ),
      .we_b_i       ( we_b_i       )
   );

   // 20 ns period
   initial
      clk = 1'b0;
   always #10 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Random source and error reporting
   ////////////////////////////////////////////////////////////////////////////

   // One Galois step shifts right and folds the taps back in
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      if (state[0])
         return (state >> 1) ^ LFSR_TAPS;
      return state >> 1;
   endfunction

   // Collects nbits with one LFSR step per bit
   task automatic draw_bits(input int nbits, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < nbits; i++)
      begin
         value  = {value[30:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   task automatic abort_run();
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("FAILED time=%0t signal=%s got=0x%08h expected=0x%08h", $time, sig, got, exp);
      abort_run();
   endtask

   task automatic report_error(input string what);
      $display("ERROR time=%0t %s", $time, what);
      abort_run();
   endtask

   task automatic check_word(input string sig, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
         report_mismatch(sig, got, exp);
   endtask

   // STATUS word has busy in bit 2, done in bit 1 and fail in bit 0
   function automatic logic [31:0] status_word(input logic busy, input logic done,
                                               input logic fail);
      return {29'd0, busy, done, fail};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Host port
   ////////////////////////////////////////////////////////////////////////////

   // Holds the request until ready and counts the cycles with ready low
   task automatic host_write(input logic [1:0] addr, input logic [31:0] data, output int stalls);
      logic accepted;
      @(negedge clk);
      cfg_valid_i = 1'b1;
      cfg_write_i = 1'b1;
      cfg_addr_i  = addr;
      cfg_wdata_i = data;
      accepted    = 1'b0;
      stalls      = 0;
      while (!accepted)
      begin
         @(posedge clk);
         accepted = cfg_ready_o;
         if (!accepted)
         begin
            stalls++;
            if (stalls > BIST_LIMIT)
               report_error("timed out waiting for cfg_ready_o on a host write");
         end
      end
      @(negedge clk);
      cfg_valid_i = 1'b0;
      cfg_write_i = 1'b0;
   endtask

   task automatic host_read(input logic [1:0] addr, output logic [31:0] data);
      logic accepted;
      logic seen;
      int   cycles;
      @(negedge clk);
      cfg_valid_i = 1'b1;
      cfg_write_i = 1'b0;
      cfg_addr_i  = addr;
      accepted    = 1'b0;
      cycles      = 0;
      while (!accepted)
      begin
         @(posedge clk);
         accepted = cfg_ready_o;
         cycles++;
         if (!accepted && (cycles > WAIT_LIMIT))
            report_error("timed out waiting for cfg_ready_o on a host read");
      end
      @(negedge clk);
      cfg_valid_i = 1'b0;
      seen        = 1'b0;
      cycles      = 0;
      while (!seen)
      begin
         @(posedge clk);
         seen = cfg_rvalid_o;
         cycles++;
         if (!seen && (cycles > WAIT_LIMIT))
            report_error("timed out waiting for cfg_rvalid_o after a host read");
      end
      data = cfg_rdata_o;
   endtask

   task automatic host_check(input logic [1:0] addr, input logic [31:0] exp, input string sig);
      logic [31:0] data;
      host_read(addr, data);
      check_word(sig, data, exp);
   endtask

   // rvalid must follow every accepted read by exactly one cycle
   always @(posedge clk)
   begin
      if (rst_n)
         check_word("cfg_rvalid_o", 32'(cfg_rvalid_o), 32'(rd_accept_q));
      rd_accept_q <= rst_n && cfg_valid_i && cfg_ready_o && !cfg_write_i;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Functional ports
   ////////////////////////////////////////////////////////////////////////////

   // Reads see the contents before this edge and the shadow takes the writes after the check
   task automatic func_cycle(input int mode);
      logic [31:0] r;
      @(negedge clk);
      draw_bits(`RF_ADDR_WIDTH, r);
      waddr_a_i = r[`RF_ADDR_WIDTH-1:0];
      draw_bits(`RF_DATA_WIDTH, r);
      wdata_a_i = r;
      draw_bits(`RF_ADDR_WIDTH, r);
      waddr_b_i = r[`RF_ADDR_WIDTH-1:0];
      draw_bits(`RF_DATA_WIDTH, r);
      wdata_b_i = r;
      draw_bits(2, r);
      we_a_i = r[0];
      we_b_i = r[1];
      draw_bits(3 * `RF_ADDR_WIDTH, r);
      raddr_a_i = r[`RF_ADDR_WIDTH-1:0];
      raddr_b_i = r[2*`RF_ADDR_WIDTH-1:`RF_ADDR_WIDTH];
      raddr_c_i = r[3*`RF_ADDR_WIDTH-1:2*`RF_ADDR_WIDTH];
      case (mode)
         MODE_COLLIDE:
         begin
            waddr_b_i = waddr_a_i;
            we_a_i    = 1'b1;
            we_b_i    = 1'b1;
         end
         MODE_ZERO:
         begin
            waddr_a_i = '0;
            waddr_b_i = '0;
            we_a_i    = 1'b1;
            we_b_i    = 1'b1;
         end
         MODE_READ:
         begin
            we_a_i = 1'b0;
            we_b_i = 1'b0;
         end
         default:
            ;
      endcase
      @(posedge clk);
      // Port A returns test data during a run and is not checked then
      if (mode != MODE_BLIND)
      begin
         check_word("rdata_a_o", rdata_a_o, shadow[raddr_a_i]);
         check_word("rdata_b_o", rdata_b_o, shadow[raddr_b_i]);
         check_word("rdata_c_o", rdata_c_o, shadow[raddr_c_i]);
         // Port B goes last and wins a collision
         if (we_a_i && (waddr_a_i != '0))
            shadow[waddr_a_i] = wdata_a_i;
         if (we_b_i && (waddr_b_i != '0))
            shadow[waddr_b_i] = wdata_b_i;
      end
   endtask

   // Every address on all three read ports
   task automatic sweep_check();
      for (int i = 0; i < NUM_WORDS; i++)
      begin
         @(negedge clk);
         we_a_i    = 1'b0;
         we_b_i    = 1'b0;
         raddr_a_i = `RF_ADDR_WIDTH'(i);
         raddr_b_i = `RF_ADDR_WIDTH'(i);
         raddr_c_i = `RF_ADDR_WIDTH'(i);
         @(posedge clk);
         check_word("rdata_a_o", rdata_a_o, shadow[i]);
         check_word("rdata_b_o", rdata_b_o, shadow[i]);
         check_word("rdata_c_o", rdata_c_o, shadow[i]);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      rst_n       = 1'b0;
      cfg_valid_i = 1'b0;
      cfg_write_i = 1'b0;
      cfg_addr_i  = '0;
      cfg_wdata_i = '0;
      raddr_a_i   = '0;
      raddr_b_i   = '0;
      raddr_c_i   = '0;
      waddr_a_i   = '0;
      wdata_a_i   = '0;
      we_a_i      = 1'b0;
      waddr_b_i   = '0;
      wdata_b_i   = '0;
      we_b_i      = 1'b0;
      rd_accept_q = 1'b0;
      lfsr_q      = LFSR_SEED;
      for (int i = 0; i < NUM_WORDS; i++)
         shadow[i] = '0;

      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // After reset everything reads zero
      @(posedge clk);
      check_word("cfg_rvalid_o", 32'(cfg_rvalid_o), 32'd0);
      repeat (8) func_cycle(MODE_READ);
      host_check(STATUS, status_word(1'b0, 1'b0, 1'b0), "STATUS");

      // Random traffic with collisions and x0 writes mixed in
      for (int i = 0; i < 64; i++)
      begin
         if ((i % 8) == 3)
            func_cycle(MODE_COLLIDE);
         else if ((i % 8) == 5)
            func_cycle(MODE_ZERO);
         else
            func_cycle(MODE_RAND);
      end
      func_cycle(MODE_READ);
      sweep_check();

      // PATTERN round trip
      draw_bits(32, pat);
      host_write(PATTERN, pat, stalls);
      // An idle engine accepts writes at once
      assert (stalls == 0)
      else
         report_error("host write stalled while the BIST was idle");
      host_check(PATTERN, pat, "PATTERN");
      host_check(PATTERN, pat, "PATTERN");

      // BIST start with busy seen by a read during the run
      host_write(CTRL, 32'd1, stalls);
      host_check(STATUS, status_word(1'b1, 1'b0, 1'b0), "STATUS");
      // Functional writes during the run must be masked
      repeat (16) func_cycle(MODE_BLIND);
      @(negedge clk);
      we_a_i = 1'b0;
      we_b_i = 1'b0;
      host_check(PATTERN, pat, "PATTERN");

      // This write stalls until the run is done
      draw_bits(32, pat_next);
      host_write(PATTERN, pat_next, stalls);
      assert (stalls > 0)
      else
         report_error("host write was accepted while the BIST was busy");
      host_check(STATUS, status_word(1'b0, 1'b1, 1'b0), "STATUS");
      host_check(PATTERN, pat_next, "PATTERN");

      // March leaves ~P everywhere except x0
      for (int i = 1; i < NUM_WORDS; i++)
         shadow[i] = ~pat;
      sweep_check();
      host_check(FAIL_ADDR, 32'd0, "FAIL_ADDR");

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+.
rf_pkg.sv
rf_test_if.sv
rf_regfile.sv
rf_test_wrap.sv
rf_mbist_ctrl.sv
rf_bist_regs.sv
rf_subsys_top.sv
tb_rf_subsys.sv
